//--- alu/alu.sv
`timescale 1ns/1ps

module alu (
    input  ex_pkg::alu_op_e         op_i,
    input  logic                    word_i,
    input  logic [ex_pkg::xlen-1:0] a_i,
    input  logic [ex_pkg::xlen-1:0] b_i,
    output logic [ex_pkg::xlen-1:0] result_o
);

    localparam int shamt_w = $clog2(ex_pkg::xlen);

    logic [shamt_w-1:0]      shamt;
    logic [ex_pkg::xlen-1:0] srl_src;
    logic [ex_pkg::xlen-1:0] sra_src;
    logic                    lt_s;
    logic                    lt_u;
    logic [ex_pkg::xlen-1:0] res;

    // word forms only use 5 bits of shift amount
    assign shamt = word_i ? {1'b0, b_i[4:0]} : b_i[shamt_w-1:0];

    // right shift sources
    // word mode looks only at the low half of a
    assign srl_src = word_i ? {32'b0, a_i[31:0]} : a_i;
    assign sra_src = word_i ? {{32{a_i[31]}}, a_i[31:0]} : a_i;

    // compares for slt and sltu
    assign lt_s = $signed(a_i) < $signed(b_i);
    assign lt_u = a_i < b_i;

    always_comb begin
        case (op_i)
            ex_pkg::alu_add: begin
                res = a_i + b_i;
            end
            ex_pkg::alu_sub: begin
                res = a_i - b_i;
            end
            ex_pkg::alu_sll: begin
                res = a_i << shamt;
            end
            ex_pkg::alu_slt: begin
                res = {{(ex_pkg::xlen-1){1'b0}}, lt_s};
            end
            ex_pkg::alu_sltu: begin
                res = {{(ex_pkg::xlen-1){1'b0}}, lt_u};
            end
            ex_pkg::alu_xor: begin
                res = a_i ^ b_i;
            end
            ex_pkg::alu_srl: begin
                res = srl_src >> shamt;
            end
            ex_pkg::alu_sra: begin
                // sign comes from bit 31 in word mode
                res = $signed(sra_src) >>> shamt;
            end
            ex_pkg::alu_or: begin
                res = a_i | b_i;
            end
            ex_pkg::alu_and: begin
                res = a_i & b_i;
            end
            default: begin
                res = '0;
            end
        endcase
    end

    // word ops sign-extend the low 32 bits
    assign result_o = word_i ? {{32{res[31]}}, res[31:0]} : res;

endmodule

//--- common/ex_pkg.sv
package ex_pkg;

    // rv64 datapath widths
    localparam int xlen       = 64;
    localparam int ilen       = 32;
    localparam int reg_addr_w = 5;
    // one strobe bit per byte of a double word
    localparam int strb_w     = xlen / 8;

    // alu operations, word forms selected by word_op
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_e;

    // first alu source
    typedef enum logic [1:0] {
        src1_rs1  = 2'd0,
        src1_pc   = 2'd1,
        src1_zero = 2'd2
    } src1_sel_e;

    // second alu source, four is the link increment
    typedef enum logic [2:0] {
        src2_rs2   = 3'd0,
        src2_imm_i = 3'd1,
        src2_imm_s = 3'd2,
        src2_imm_u = 3'd3,
        src2_four  = 3'd4
    } src2_sel_e;

    // control transfer kind
    typedef enum logic [3:0] {
        br_none = 4'd0,
        br_beq  = 4'd1,
        br_bne  = 4'd2,
        br_blt  = 4'd3,
        br_bge  = 4'd4,
        br_bltu = 4'd5,
        br_bgeu = 4'd6,
        br_jal  = 4'd7,
        br_jalr = 4'd8
    } br_op_e;

    // access size, encoded as log2 of the byte count
    typedef enum logic [1:0] {
        mem_byte   = 2'd0,
        mem_half   = 2'd1,
        mem_word   = 2'd2,
        mem_double = 2'd3
    } mem_size_e;

    // decoded instruction entering execute
    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [ilen-1:0]       inst;
        logic [xlen-1:0]       rs1_data;
        logic [xlen-1:0]       rs2_data;
        alu_op_e               alu_op;
        src1_sel_e             src1_sel;
        src2_sel_e             src2_sel;
        logic                  word_op;
        logic [reg_addr_w-1:0] rd;
        logic                  rf_we;
        logic                  mem_en;
        logic                  mem_we;
        mem_size_e             mem_size;
        logic                  load_unsigned;
        br_op_e                br_op;
    } id_ex_t;

    // sign-extended immediates, u already shifted by 12
    typedef struct packed {
        logic [xlen-1:0] i;
        logic [xlen-1:0] s;
        logic [xlen-1:0] b;
        logic [xlen-1:0] u;
        logic [xlen-1:0] j;
    } imm_t;

    // execute result handed to the memory stage
    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       result;
        logic [reg_addr_w-1:0] rd;
        logic                  rf_we;
        logic                  mem_en;
        logic                  mem_we;
        mem_size_e             mem_size;
        logic                  load_unsigned;
        logic [strb_w-1:0]     mem_strb;
        logic [xlen-1:0]       mem_wdata;
        logic                  br_taken;
        logic [xlen-1:0]       br_target;
    } ex_mem_t;

endpackage

//--- compile.f
common/ex_pkg.sv
design/pipe_reg.sv
design/operand_sel.sv
alu/alu.sv
design/branch_unit.sv
design/mem_req_gen.sv
design/ex_stage.sv
sim/ex_stage_asserts.sv
sim/tb_ex_stage.sv

//--- design/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  ex_pkg::br_op_e          op_i,
    input  logic [ex_pkg::xlen-1:0] pc_i,
    input  logic [ex_pkg::xlen-1:0] rs1_i,
    input  logic [ex_pkg::xlen-1:0] rs2_i,
    input  ex_pkg::imm_t            imm_i,
    output logic                    taken_o,
    output logic [ex_pkg::xlen-1:0] target_o
);

    logic                    eq;
    logic                    lt_s;
    logic                    lt_u;
    logic [ex_pkg::xlen-1:0] target;

    // operand compares
    assign eq   = rs1_i == rs2_i;
    assign lt_s = $signed(rs1_i) < $signed(rs2_i);
    assign lt_u = rs1_i < rs2_i;

    always_comb begin
        // default is pc relative branch target
        target = pc_i + imm_i.b;
        case (op_i)
            ex_pkg::br_beq:  taken_o = eq;
            ex_pkg::br_bne:  taken_o = !eq;
            ex_pkg::br_blt:  taken_o = lt_s;
            ex_pkg::br_bge:  taken_o = !lt_s;
            ex_pkg::br_bltu: taken_o = lt_u;
            ex_pkg::br_bgeu: taken_o = !lt_u;
            ex_pkg::br_jal: begin
                taken_o = 1'b1;
                target  = pc_i + imm_i.j;
            end
            ex_pkg::br_jalr: begin
                taken_o = 1'b1;
                // lsb forced low per spec
                target  = (rs1_i + imm_i.i) & ~ex_pkg::xlen'(1);
            end
            default: taken_o = 1'b0;
        endcase
    end

    // no target unless redirecting
    assign target_o = taken_o ? target : '0;

endmodule

//--- design/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush_i,
    // from decode
    input  logic            in_valid_i,
    input  ex_pkg::id_ex_t  in_data_i,
    output logic            in_ready_o,
    // to memory stage
    output logic            out_valid_o,
    output ex_pkg::ex_mem_t out_data_o,
    input  logic            out_ready_i
);

    // registered decode payload
    logic                    id_valid;
    ex_pkg::id_ex_t          id_q;
    // back-pressure from the output register
    logic                    ex_ready;

    logic [ex_pkg::xlen-1:0] src1;
    logic [ex_pkg::xlen-1:0] src2;
    ex_pkg::imm_t            imm;
    logic [ex_pkg::xlen-1:0] alu_result;
    logic                    br_taken;
    logic [ex_pkg::xlen-1:0] br_target;
    ex_pkg::ex_mem_t         ex_d;

    // first slot holds the decoded instruction
    pipe_reg #(
        .T (ex_pkg::id_ex_t)
    ) u_id_ex (
        .clk     (clk),
        .rst     (rst),
        .flush_i (flush_i),
        .valid_i (in_valid_i),
        .data_i  (in_data_i),
        .ready_o (in_ready_o),
        .valid_o (id_valid),
        .data_o  (id_q),
        .ready_i (ex_ready)
    );

    operand_sel u_operand_sel (
        .id_i   (id_q),
        .src1_o (src1),
        .src2_o (src2),
        .imm_o  (imm)
    );

    alu u_alu (
        .op_i     (id_q.alu_op),
        .word_i   (id_q.word_op),
        .a_i      (src1),
        .b_i      (src2),
        .result_o (alu_result)
    );

    // compares use raw register values, not alu operands
    branch_unit u_branch_unit (
        .op_i     (id_q.br_op),
        .pc_i     (id_q.pc),
        .rs1_i    (id_q.rs1_data),
        .rs2_i    (id_q.rs2_data),
        .imm_i    (imm),
        .taken_o  (br_taken),
        .target_o (br_target)
    );

    mem_req_gen u_mem_req_gen (
        .id_i     (id_q),
        .result_i (alu_result),
        .taken_i  (br_taken),
        .target_i (br_target),
        .ex_o     (ex_d)
    );

    // second slot drives the stage output
    pipe_reg #(
        .T (ex_pkg::ex_mem_t)
    ) u_ex_mem (
        .clk     (clk),
        .rst     (rst),
        .flush_i (flush_i),
        .valid_i (id_valid),
        .data_i  (ex_d),
        .ready_o (ex_ready),
        .valid_o (out_valid_o),
        .data_o  (out_data_o),
        .ready_i (out_ready_i)
    );

endmodule

//--- design/mem_req_gen.sv
`timescale 1ns/1ps

module mem_req_gen (
    input  ex_pkg::id_ex_t          id_i,
    input  logic [ex_pkg::xlen-1:0] result_i,
    input  logic                    taken_i,
    input  logic [ex_pkg::xlen-1:0] target_i,
    output ex_pkg::ex_mem_t         ex_o
);

    localparam int off_w = $clog2(ex_pkg::strb_w);

    logic                      is_store;
    logic [off_w-1:0]          offset;
    logic [ex_pkg::strb_w-1:0] strb_base;
    logic [ex_pkg::xlen-1:0]   data_mask;

    assign is_store = id_i.mem_en && id_i.mem_we;
    // byte lane within the double word
    assign offset   = result_i[off_w-1:0];

    // lanes covered by the access, before shifting
    always_comb begin
        case (id_i.mem_size)
            ex_pkg::mem_byte: begin
                strb_base = ex_pkg::strb_w'(8'h01);
                data_mask = ex_pkg::xlen'(64'hff);
            end
            ex_pkg::mem_half: begin
                strb_base = ex_pkg::strb_w'(8'h03);
                data_mask = ex_pkg::xlen'(64'hffff);
            end
            ex_pkg::mem_word: begin
                strb_base = ex_pkg::strb_w'(8'h0f);
                data_mask = ex_pkg::xlen'(64'hffff_ffff);
            end
            default: begin
                strb_base = '1;
                data_mask = '1;
            end
        endcase
    end

    always_comb begin
        ex_o.pc            = id_i.pc;
        // alu result doubles as address and writeback value
        ex_o.result        = result_i;
        ex_o.rd            = id_i.rd;
        ex_o.rf_we         = id_i.rf_we;
        // load control passes straight through
        ex_o.mem_en        = id_i.mem_en;
        ex_o.mem_we        = id_i.mem_we;
        ex_o.mem_size      = id_i.mem_size;
        ex_o.load_unsigned = id_i.load_unsigned;
        ex_o.mem_strb      = '0;
        ex_o.mem_wdata     = '0;
        if (is_store) begin
            ex_o.mem_strb  = strb_base << offset;
            // rs2 low bytes moved onto the addressed lanes
            ex_o.mem_wdata = (id_i.rs2_data & data_mask) << {offset, 3'b000};
        end
        ex_o.br_taken      = taken_i;
        ex_o.br_target     = target_i;
    end

endmodule

//--- design/operand_sel.sv
`timescale 1ns/1ps

module operand_sel (
    input  ex_pkg::id_ex_t          id_i,
    output logic [ex_pkg::xlen-1:0] src1_o,
    output logic [ex_pkg::xlen-1:0] src2_o,
    output ex_pkg::imm_t            imm_o
);

    logic [ex_pkg::ilen-1:0] inst;

    assign inst = id_i.inst;

    // i type, inst[31:20]
    assign imm_o.i = {{(ex_pkg::xlen-12){inst[31]}}, inst[31:20]};

    // s type, split around rd field
    assign imm_o.s = {{(ex_pkg::xlen-12){inst[31]}}, inst[31:25], inst[11:7]};

    // b type, halfword offset with bit 0 implied
    assign imm_o.b = {{(ex_pkg::xlen-13){inst[31]}}, inst[31], inst[7],
                      inst[30:25], inst[11:8], 1'b0};

    // u type, already placed at bit 12
    assign imm_o.u = {{(ex_pkg::xlen-32){inst[31]}}, inst[31:12], 12'b0};

    // j type, scrambled 20-bit offset
    assign imm_o.j = {{(ex_pkg::xlen-21){inst[31]}}, inst[31], inst[19:12],
                      inst[20], inst[30:21], 1'b0};

    // first operand
    // pc for auipc and link, zero for lui
    always_comb begin
        case (id_i.src1_sel)
            ex_pkg::src1_rs1:  src1_o = id_i.rs1_data;
            ex_pkg::src1_pc:   src1_o = id_i.pc;
            ex_pkg::src1_zero: src1_o = '0;
            default:           src1_o = '0;
        endcase
    end

    // second operand
    // s immediate feeds the store address add
    always_comb begin
        case (id_i.src2_sel)
            ex_pkg::src2_rs2:   src2_o = id_i.rs2_data;
            ex_pkg::src2_imm_i: src2_o = imm_o.i;
            ex_pkg::src2_imm_s: src2_o = imm_o.s;
            ex_pkg::src2_imm_u: src2_o = imm_o.u;
            // pc + 4 for jal and jalr link
            ex_pkg::src2_four:  src2_o = ex_pkg::xlen'(4);
            default:            src2_o = '0;
        endcase
    end

endmodule

//--- design/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst,
    input  logic flush_i,
    // upstream side
    input  logic valid_i,
    input  T     data_i,
    output logic ready_o,
    // downstream side
    output logic valid_o,
    output T     data_o,
    input  logic ready_i
);

    logic valid_q;
    T     data_q;

    // accept when empty or when the held item leaves this cycle
    assign ready_o = !valid_q || ready_i;

    // valid bit, cleared by reset and flush
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            // also drops an item handshaked this cycle
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    // payload only moves on a handshake, held under stall
    always_ff @(posedge clk) begin
        if (ready_o && valid_i) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule

//--- run.sh
#!/bin/sh
# build and run the ex_stage testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 -f compile.f --top-module tb_ex_stage \
    -Mdir obj_dir -o sim_ex_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_ex_stage +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" sim.log; then
    exit 1
fi
exit 0

//--- sim/ex_stage_asserts.sv
`timescale 1ns/1ps

module ex_stage_asserts (
    input logic            clk,
    input logic            rst,
    input logic            flush_i,
    input logic            out_valid_i,
    input logic            out_ready_i,
    input ex_pkg::ex_mem_t out_data_i,
    input logic            in_ready_i
);

    // failures seen so far, summed into the testbench total
    int fail_count = 0;

    // a stalled output item stays put until taken, unless flushed
    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        (out_valid_i && !out_ready_i && !flush_i) |=> (out_valid_i && $stable(out_data_i)))
        else begin
            $error("output item changed or vanished while stalled");
            fail_count++;
        end

    // reset empties the output slot
    a_reset_empty: assert property (@(posedge clk) rst |=> !out_valid_i)
        else begin
            $error("output valid high right after a reset edge");
            fail_count++;
        end

    // first two cycles out of reset stay empty
    a_reset_exit: assert property (@(posedge clk) $fell(rst) |-> !out_valid_i ##1 !out_valid_i)
        else begin
            $error("output valid high too soon after reset");
            fail_count++;
        end

    // empty output slot never blocks the input
    a_ready_empty: assert property (@(posedge clk) disable iff (rst) !out_valid_i |-> in_ready_i)
        else begin
            $error("input ready low with the output slot empty");
            fail_count++;
        end

endmodule

bind ex_stage ex_stage_asserts u_ex_stage_asserts (
    .clk         (clk),
    .rst         (rst),
    .flush_i     (flush_i),
    .out_valid_i (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_i  (out_data_o),
    .in_ready_i  (in_ready_o)
);

//--- sim/tb_ex_stage.sv
`timescale 1ns/1ps

module tb_ex_stage;

    localparam int seed_init   = 19726;
    // alu, branch, store, backpressure, flush
    localparam int total_items = 300 + 300 + 200 + 400 + 200;

    logic            clk;
    logic            rst;
    logic            flush_i;
    logic            in_valid_i;
    ex_pkg::id_ex_t  in_data_i;
    logic            in_ready_o;
    logic            out_valid_o;
    ex_pkg::ex_mem_t out_data_o;
    logic            out_ready_i;

    integer          seed = seed_init;
    int              errors = 0;
    int              checks = 0;
    int              sent;
    logic            accepted = 1'b0;
    string           test_name = "reset";
    ex_pkg::ex_mem_t exp_q[$];
    ex_pkg::ex_mem_t exp_item;

    ex_stage u_ex_stage (
        .clk         (clk),
        .rst         (rst),
        .flush_i     (flush_i),
        .in_valid_i  (in_valid_i),
        .in_data_i   (in_data_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_data_o),
        .out_ready_i (out_ready_i)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] rnd32();
        return $random(seed);
    endfunction

    // random decoded instruction, cat 0 alu, 1 branch, 2 load/store, 3 any
    function automatic ex_pkg::id_ex_t make_item(input int cat);
        ex_pkg::id_ex_t d;
        logic [31:0]    r;
        int             c;
        int             off;
        c = (cat == 3) ? int'(rnd32() % 3) : cat;
        r = rnd32();
        d.pc = {rnd32(), rnd32()} & ~64'd3;
        d.inst = rnd32();
        d.rs1_data = {rnd32(), rnd32()};
        d.rs2_data = {rnd32(), rnd32()};
        d.alu_op = ex_pkg::alu_op_e'(4'(rnd32() % 10));
        d.src1_sel = ex_pkg::src1_sel_e'(2'(rnd32() % 3));
        d.src2_sel = ex_pkg::src2_sel_e'(3'(rnd32() % 5));
        d.word_op = r[0];
        d.rd = 5'(rnd32());
        d.rf_we = r[1];
        d.mem_en = 1'b0;
        d.mem_we = r[2];
        d.mem_size = ex_pkg::mem_size_e'(r[5:4]);
        d.load_unsigned = r[3];
        d.br_op = ex_pkg::br_none;
        if (c == 1) begin
            // link computed as pc + 4
            d.br_op = ex_pkg::br_op_e'(4'(1 + rnd32() % 8));
            d.src1_sel = ex_pkg::src1_pc;
            d.src2_sel = ex_pkg::src2_four;
            d.alu_op = ex_pkg::alu_add;
            d.word_op = 1'b0;
            // equal, less, greater and sign corner pairs
            case (rnd32() % 5)
                0: d.rs2_data = d.rs1_data;
                1: d.rs2_data = d.rs1_data + 64'd1;
                2: d.rs2_data = d.rs1_data - 64'd1;
                3: begin
                    d.rs1_data = 64'h8000_0000_0000_0000;
                    d.rs2_data = 64'd1;
                end
                default: begin
                    d.rs1_data = '1;
                    d.rs2_data = '0;
                end
            endcase
        end else if (c == 2) begin
            d.mem_en = 1'b1;
            d.src1_sel = ex_pkg::src1_rs1;
            d.src2_sel = ex_pkg::src2_imm_s;
            d.alu_op = ex_pkg::alu_add;
            d.word_op = 1'b0;
            // pick an aligned lane, then cancel the immediate's low bits
            off = int'(rnd32() % 8) & ~((1 << int'(d.mem_size)) - 1);
            d.rs1_data[2:0] = 3'(off - int'(d.inst[9:7]));
        end
        return d;
    endfunction

    // expected memory-stage payload from the rv64 rules
    function automatic ex_pkg::ex_mem_t expect_ex(input ex_pkg::id_ex_t d);
        logic [63:0]     i_imm;
        logic [63:0]     s_imm;
        logic [63:0]     b_imm;
        logic [63:0]     u_imm;
        logic [63:0]     j_imm;
        logic [63:0]     a;
        logic [63:0]     b;
        logic [63:0]     r;
        logic [63:0]     tgt;
        logic [31:0]     w;
        logic            tk;
        int              off;
        int              nb;
        ex_pkg::ex_mem_t e;
        i_imm = 64'($signed(d.inst[31:20]));
        s_imm = 64'($signed({d.inst[31:25], d.inst[11:7]}));
        b_imm = 64'($signed({d.inst[31], d.inst[7], d.inst[30:25], d.inst[11:8], 1'b0}));
        u_imm = 64'($signed({d.inst[31:12], 12'h000}));
        j_imm = 64'($signed({d.inst[31], d.inst[19:12], d.inst[20], d.inst[30:21], 1'b0}));
        case (d.src1_sel)
            ex_pkg::src1_pc:   a = d.pc;
            ex_pkg::src1_zero: a = '0;
            default:           a = d.rs1_data;
        endcase
        case (d.src2_sel)
            ex_pkg::src2_imm_i: b = i_imm;
            ex_pkg::src2_imm_s: b = s_imm;
            ex_pkg::src2_imm_u: b = u_imm;
            ex_pkg::src2_four:  b = 64'd4;
            default:            b = d.rs2_data;
        endcase
        case (d.alu_op)
            ex_pkg::alu_add:  r = a + b;
            ex_pkg::alu_sub:  r = a - b;
            ex_pkg::alu_sll:  r = a << b[5:0];
            ex_pkg::alu_slt:  r = {63'd0, $signed(a) < $signed(b)};
            ex_pkg::alu_sltu: r = {63'd0, a < b};
            ex_pkg::alu_xor:  r = a ^ b;
            ex_pkg::alu_srl:  r = a >> b[5:0];
            ex_pkg::alu_sra:  r = $signed(a) >>> b[5:0];
            ex_pkg::alu_or:   r = a | b;
            ex_pkg::alu_and:  r = a & b;
            default:          r = '0;
        endcase
        if (d.word_op) begin
            // 32-bit shifts on the low half, then sign-extend
            case (d.alu_op)
                ex_pkg::alu_sll: w = a[31:0] << b[4:0];
                ex_pkg::alu_srl: w = a[31:0] >> b[4:0];
                ex_pkg::alu_sra: w = $signed(a[31:0]) >>> b[4:0];
                default:         w = r[31:0];
            endcase
            r = 64'($signed(w));
        end
        case (d.br_op)
            ex_pkg::br_beq:  tk = d.rs1_data == d.rs2_data;
            ex_pkg::br_bne:  tk = d.rs1_data != d.rs2_data;
            ex_pkg::br_blt:  tk = $signed(d.rs1_data) < $signed(d.rs2_data);
            ex_pkg::br_bge:  tk = $signed(d.rs1_data) >= $signed(d.rs2_data);
            ex_pkg::br_bltu: tk = d.rs1_data < d.rs2_data;
            ex_pkg::br_bgeu: tk = d.rs1_data >= d.rs2_data;
            ex_pkg::br_jal:  tk = 1'b1;
            ex_pkg::br_jalr: tk = 1'b1;
            default:         tk = 1'b0;
        endcase
        case (d.br_op)
            ex_pkg::br_jal:  tgt = d.pc + j_imm;
            ex_pkg::br_jalr: tgt = (d.rs1_data + i_imm) & ~64'd1;
            default:         tgt = d.pc + b_imm;
        endcase
        e.pc = d.pc;
        e.result = r;
        e.rd = d.rd;
        e.rf_we = d.rf_we;
        e.mem_en = d.mem_en;
        e.mem_we = d.mem_we;
        e.mem_size = d.mem_size;
        e.load_unsigned = d.load_unsigned;
        e.mem_strb = '0;
        e.mem_wdata = '0;
        // store bytes land on lanes off .. off+nb-1
        if (d.mem_en && d.mem_we) begin
            off = int'(r[2:0]);
            nb = 1 << int'(d.mem_size);
            for (int k = 0; k < 8; k++) begin
                if (k >= off && k < off + nb) begin
                    e.mem_strb[k] = 1'b1;
                    e.mem_wdata[8*k +: 8] = d.rs2_data[8*(k-off) +: 8];
                end
            end
        end
        e.br_taken = tk;
        e.br_target = tk ? tgt : '0;
        return e;
    endfunction

    task automatic compare_field(input string field, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            $display("Fail %s %s: expected %h, actual %h", test_name, field, exp_v, act_v);
        end
    endtask

    // one cycle of stimulus, handshakes sampled once inputs have settled
    task automatic drive_cycle(input int cat, input int n, input int vpct, input int rpct,
                               input int fpct);
        @(negedge clk);
        if (accepted) begin
            in_valid_i = 1'b0;
        end
        flush_i = (rnd32() % 100) < 32'(fpct);
        out_ready_i = !flush_i && ((rnd32() % 100) < 32'(rpct));
        if (!in_valid_i && sent < n && (rnd32() % 100) < 32'(vpct)) begin
            in_data_i = make_item(cat);
            in_valid_i = 1'b1;
        end
        #1;
        accepted = in_valid_i && in_ready_o;
        if (accepted) begin
            sent++;
            if (!flush_i) begin
                exp_q.push_back(expect_ex(in_data_i));
            end
        end
        // everything in flight is dropped
        if (flush_i) begin
            exp_q.delete();
        end
    endtask

    task automatic run_phase(input string name, input int cat, input int n, input int vpct,
                             input int rpct, input int fpct);
        test_name = name;
        sent = 0;
        while (sent < n) begin
            drive_cycle(cat, n, vpct, rpct, fpct);
        end
        // drain with the output always ready
        while (exp_q.size() != 0) begin
            drive_cycle(cat, n, 100, 100, 0);
        end
    endtask

    // scoreboard, pops on every output handshake
    always begin
        @(negedge clk);
        #1;
        if (out_valid_o && out_ready_i) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("an output item appeared with none pending in test %s", test_name);
            end else begin
                exp_item = exp_q.pop_front();
                compare_field("pc", exp_item.pc, out_data_o.pc);
                compare_field("result", exp_item.result, out_data_o.result);
                compare_field("rd", 64'(exp_item.rd), 64'(out_data_o.rd));
                compare_field("rf_we", 64'(exp_item.rf_we), 64'(out_data_o.rf_we));
                compare_field("mem_en", 64'(exp_item.mem_en), 64'(out_data_o.mem_en));
                compare_field("mem_we", 64'(exp_item.mem_we), 64'(out_data_o.mem_we));
                compare_field("mem_size", 64'(exp_item.mem_size), 64'(out_data_o.mem_size));
                compare_field("load_unsigned", 64'(exp_item.load_unsigned),
                              64'(out_data_o.load_unsigned));
                compare_field("mem_strb", 64'(exp_item.mem_strb), 64'(out_data_o.mem_strb));
                compare_field("mem_wdata", exp_item.mem_wdata, out_data_o.mem_wdata);
                compare_field("br_taken", 64'(exp_item.br_taken), 64'(out_data_o.br_taken));
                compare_field("br_target", exp_item.br_target, out_data_o.br_target);
            end
        end
    end

    // about ten cycles per item plus margin
    initial begin
        #((total_items * 10 + 200) * 20);
        $display("timeout: the stage stopped delivering items in test %s", test_name);
        $display("Errors found");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        flush_i = 1'b0;
        in_valid_i = 1'b0;
        in_data_i = '0;
        out_ready_i = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        compare_field("out_valid_o", 64'd0, 64'(out_valid_o));
        compare_field("in_ready_o", 64'd1, 64'(in_ready_o));
        run_phase("alu", 0, 300, 100, 100, 0);
        run_phase("branch", 1, 300, 100, 100, 0);
        run_phase("store", 2, 200, 100, 100, 0);
        run_phase("backpressure", 3, 400, 60, 50, 0);
        run_phase("flush", 3, 200, 70, 70, 5);
        errors += u_ex_stage.u_ex_stage_asserts.fail_count;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
